//--- logic/sdram_pkg.sv
package sdram_pkg;

	// Device geometry, 16-bit four-bank part
	localparam int BANK_W = 2;
	localparam int ROW_W = 13;
	localparam int COL_W = 9;
	localparam int DATA_W = 16;
	localparam int ADDR_W = BANK_W + ROW_W + COL_W;

	// Command placed on the pins in a cycle
	typedef enum logic [2:0] {
		NOP,
		READ,
		WRITE,
		ACT,
		PRE,
		PALL,
		REF,
		MRS
	} sdram_cmd_e;

	// Request address, flat or split into bank, row and column
	typedef union packed {
		logic [ADDR_W-1:0] word;
		struct packed {
			logic [BANK_W-1:0] bank;
			logic [ROW_W-1:0] row;
			logic [COL_W-1:0] col;
		} loc;
	} sdram_addr_u;

endpackage

//--- logic/request_queue.sv
`timescale 1ns/10ps

module request_queue #(
	parameter int QUEUE_DEPTH_LOG = 3
) (
	input logic clk,
	input logic n_reset,
	input logic push,
	input logic we,
	input sdram_pkg::sdram_addr_u addr_in,
	input logic [sdram_pkg::DATA_W-1:0] data_in,
	input logic pop,
	output logic full,
	output logic empty,
	output logic q_we,
	output sdram_pkg::sdram_addr_u q_addr,
	output logic [sdram_pkg::DATA_W-1:0] q_data
);

	import sdram_pkg::*;

	localparam int DEPTH = 2 ** QUEUE_DEPTH_LOG;

	logic we_mem [DEPTH];
	sdram_addr_u addr_mem [DEPTH];
	logic [DATA_W-1:0] data_mem [DEPTH];

	logic [QUEUE_DEPTH_LOG-1:0] wr_ptr;
	logic [QUEUE_DEPTH_LOG-1:0] rd_ptr;
	logic [QUEUE_DEPTH_LOG:0] count;

	always_ff @(posedge clk) begin
		if (push) begin
			we_mem[wr_ptr] <= we;
			addr_mem[wr_ptr] <= addr_in;
			data_mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Top bit of the count is set only at DEPTH
	assign full = count[QUEUE_DEPTH_LOG];
	assign empty = (count == '0);

	assign q_we = we_mem[rd_ptr];
	assign q_addr = addr_mem[rd_ptr];
	assign q_data = data_mem[rd_ptr];

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!n_reset)
		pop |-> !empty);
	a_no_push_full: assert property (@(posedge clk) disable iff (!n_reset)
		push |-> !full);

endmodule

//--- logic/command_sequencer.sv
`timescale 1ns/10ps

module command_sequencer #(
	parameter int CAS = 3,
	parameter int TINIT = 14300,
	parameter int TREFC = 1117,
	parameter int TRC = 9,
	parameter int TRP = 3,
	parameter int TMRD = 2,
	parameter int TRCD = 3
) (
	input logic clk,
	input logic n_reset,
	input logic empty,
	input logic q_we,
	input sdram_pkg::sdram_addr_u q_addr,
	input logic [sdram_pkg::DATA_W-1:0] q_data,
	output logic pop,
	output sdram_pkg::sdram_cmd_e cmd,
	output logic dq_drive,
	output logic [sdram_pkg::DATA_W-1:0] dq_out,
	output logic dram_cke,
	output logic dram_ras_n,
	output logic dram_cas_n,
	output logic dram_we_n,
	output logic [sdram_pkg::BANK_W-1:0] dram_ba,
	output logic [sdram_pkg::ROW_W-1:0] dram_addr,
	output logic [1:0] dram_dqm
);

	import sdram_pkg::*;

	localparam int BANKS = 1 << BANK_W;
	localparam logic [2:0] CAS_CODE = 3'(CAS);
	localparam logic [15:0] INIT_LOAD = 16'(TINIT - 1);
	localparam logic [15:0] RP_LOAD = 16'(TRP - 1);
	localparam logic [15:0] RC_LOAD = 16'(TRC - 1);
	// Active window so that one full refresh period is TREFC cycles
	localparam logic [15:0] WIN_LOAD = 16'(TREFC - TRP - TRC - 1);

	typedef enum logic [2:0] {
		s_reset,
		s_init,
		s_init_pall,
		s_init_ref,
		s_active,
		s_precharge,
		s_refresh
	} state_e;

	state_e state;
	state_e state_next;
	logic [15:0] cnt;
	logic [15:0] cnt_load;
	logic [2:0] delay;
	logic [2:0] delay_load;
	logic mode;
	logic execute;
	logic [BANKS-1:0] bank_active;
	logic [ROW_W-1:0] open_row [BANKS];

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			state <= s_reset;
			cnt <= '0;
		end else if (cnt == '0) begin
			state <= state_next;
			cnt <= cnt_load;
		end else begin
			cnt <= cnt - 16'd1;
		end
	end

	// Spacing between commands in the active window
	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset)
			delay <= '0;
		else if (delay == '0)
			delay <= delay_load;
		else
			delay <= delay - 3'd1;
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset)
			mode <= 1'b0;
		else if (cmd == MRS)
			mode <= 1'b1;
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			bank_active <= '0;
		end else begin
			case (cmd)
				ACT: bank_active[q_addr.loc.bank] <= 1'b1;
				PRE: bank_active[q_addr.loc.bank] <= 1'b0;
				PALL: bank_active <= '0;
				default: bank_active <= bank_active;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd == ACT)
			open_row[q_addr.loc.bank] <= q_addr.loc.row;
	end

	always_comb begin
		state_next = state;
		cnt_load = '0;
		cmd = NOP;
		delay_load = '0;
		execute = 1'b0;
		case (state)
			s_reset: begin
				state_next = s_init;
				cnt_load = INIT_LOAD;
			end
			s_init: begin
				state_next = s_init_pall;
				cnt_load = RP_LOAD;
				if (cnt == '0)
					cmd = PALL;
			end
			s_init_pall: begin
				state_next = s_init_ref;
				cnt_load = RC_LOAD;
				if (cnt == '0)
					cmd = REF;
			end
			s_init_ref: begin
				state_next = s_refresh;
				cnt_load = RC_LOAD;
				if (cnt == '0)
					cmd = REF;
			end
			s_active: begin
				state_next = s_precharge;
				cnt_load = RP_LOAD;
				if (cnt == '0)
					cmd = PALL;
				else
					execute = 1'b1;
			end
			s_precharge: begin
				state_next = s_refresh;
				cnt_load = RC_LOAD;
				if (cnt == '0)
					cmd = REF;
			end
			s_refresh: begin
				state_next = s_active;
				cnt_load = WIN_LOAD;
			end
			default: begin
				state_next = s_reset;
			end
		endcase

		if (execute && delay == '0) begin
			if (!mode) begin
				cmd = MRS;
				delay_load = 3'(TMRD - 1);
			end else if (!empty) begin
				if (!bank_active[q_addr.loc.bank]) begin
					cmd = ACT;
					delay_load = 3'(TRCD - 1);
				end else if (open_row[q_addr.loc.bank] != q_addr.loc.row) begin
					cmd = PRE;
					delay_load = 3'(TRP - 1);
				end else begin
					cmd = q_we ? WRITE : READ;
				end
			end
		end
	end

	assign pop = (cmd == READ) || (cmd == WRITE);

	// Pin encoding
	always_comb begin
		dram_cke = 1'b1;
		dram_ras_n = 1'b1;
		dram_cas_n = 1'b1;
		dram_we_n = 1'b1;
		dram_ba = '0;
		dram_addr = '0;
		dram_dqm = 2'b00;
		dq_drive = 1'b0;
		dq_out = '0;
		if (state == s_reset) begin
			dram_cke = 1'b0;
			dram_dqm = 2'b11;
		end
		case (cmd)
			PALL: begin
				dram_ras_n = 1'b0;
				dram_we_n = 1'b0;
				dram_addr[10] = 1'b1;
			end
			REF: begin
				dram_ras_n = 1'b0;
				dram_cas_n = 1'b0;
			end
			MRS: begin
				dram_ras_n = 1'b0;
				dram_cas_n = 1'b0;
				dram_we_n = 1'b0;
				// Burst length one, sequential
				dram_addr = {3'b000, 1'b0, 2'b00, CAS_CODE, 1'b0, 3'b000};
			end
			PRE: begin
				dram_ras_n = 1'b0;
				dram_we_n = 1'b0;
				dram_ba = q_addr.loc.bank;
			end
			ACT: begin
				dram_ras_n = 1'b0;
				dram_ba = q_addr.loc.bank;
				dram_addr = q_addr.loc.row;
			end
			READ: begin
				dram_cas_n = 1'b0;
				dram_ba = q_addr.loc.bank;
				dram_addr[COL_W-1:0] = q_addr.loc.col;
			end
			WRITE: begin
				dram_cas_n = 1'b0;
				dram_we_n = 1'b0;
				dram_ba = q_addr.loc.bank;
				dram_addr[COL_W-1:0] = q_addr.loc.col;
				dq_drive = 1'b1;
				dq_out = q_data;
			end
			default: begin
			end
		endcase
	end

	a_pop_with_access: assert property (@(posedge clk) disable iff (!n_reset)
		pop |-> dram_ras_n && !dram_cas_n && dram_ba == q_addr.loc.bank);
	a_access_open_row: assert property (@(posedge clk) disable iff (!n_reset)
		(dram_ras_n && !dram_cas_n) |->
			bank_active[dram_ba] && open_row[dram_ba] == q_addr.loc.row);

endmodule

//--- logic/read_return.sv
`timescale 1ns/10ps

module read_return #(
	parameter int CAS = 3
) (
	input logic clk,
	input logic n_reset,
	input sdram_pkg::sdram_cmd_e cmd,
	input sdram_pkg::sdram_addr_u q_addr,
	input logic [sdram_pkg::DATA_W-1:0] dram_dq,
	output logic rdy_out,
	output logic [sdram_pkg::ADDR_W-1:0] addr_out,
	output logic [sdram_pkg::DATA_W-1:0] data_out
);

	import sdram_pkg::*;

	// One stage per cycle of CAS latency
	logic [CAS-1:0] rd_sr;
	logic [ADDR_W-1:0] addr_sr [CAS];

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			rd_sr <= '0;
		end else begin
			rd_sr[0] <= (cmd == READ);
			for (int i = 1; i < CAS; i++)
				rd_sr[i] <= rd_sr[i-1];
		end
	end

	always_ff @(posedge clk) begin
		addr_sr[0] <= q_addr.word;
		for (int i = 1; i < CAS; i++)
			addr_sr[i] <= addr_sr[i-1];
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset)
			rdy_out <= 1'b0;
		else
			rdy_out <= rd_sr[CAS-1];
	end

	// Data on the bus CAS cycles after the READ
	always_ff @(posedge clk) begin
		addr_out <= addr_sr[CAS-1];
		data_out <= dram_dq;
	end

	a_rdy_addr_known: assert property (@(posedge clk) disable iff (!n_reset)
		rdy_out |-> !$isunknown(addr_out));

endmodule

//--- logic/sdram_ctrl.sv
`timescale 1ns/10ps

module sdram_ctrl #(
	parameter int CAS = 3,
	parameter int TINIT = 14300,
	parameter int TREFC = 1117,
	parameter int TRC = 9,
	parameter int TRP = 3,
	parameter int TMRD = 2,
	parameter int TRCD = 3,
	parameter int QUEUE_DEPTH_LOG = 3
) (
	input logic clk,
	input logic n_reset,
	input logic en,
	input logic req,
	input logic we,
	input logic [sdram_pkg::ADDR_W-1:0] addr_in,
	input logic [sdram_pkg::DATA_W-1:0] data_in,
	output logic rdy,
	output logic rdy_out,
	output logic [sdram_pkg::ADDR_W-1:0] addr_out,
	output logic [sdram_pkg::DATA_W-1:0] data_out,
	output logic [sdram_pkg::ROW_W-1:0] DRAM_ADDR,
	output logic [sdram_pkg::BANK_W-1:0] DRAM_BA,
	output logic [1:0] DRAM_DQM,
	output logic DRAM_CKE,
	output logic DRAM_CLK,
	output logic DRAM_CS_N,
	output logic DRAM_RAS_N,
	output logic DRAM_CAS_N,
	output logic DRAM_WE_N,
	inout wire [sdram_pkg::DATA_W-1:0] DRAM_DQ
);

	import sdram_pkg::*;

	logic push;
	logic pop;
	logic full;
	logic empty;
	logic q_we;
	sdram_addr_u q_addr;
	logic [DATA_W-1:0] q_data;
	sdram_cmd_e cmd;
	logic dq_drive;
	logic [DATA_W-1:0] dq_out;

	assign DRAM_CLK = ~clk;
	assign DRAM_CS_N = ~en;

	assign rdy = ~full;
	assign push = req & rdy;

	// Bus driven only in the WRITE cycle
	assign DRAM_DQ = dq_drive ? dq_out : 'z;

	request_queue #(
		.QUEUE_DEPTH_LOG(QUEUE_DEPTH_LOG)
	) u_queue (
		.clk(clk),
		.n_reset(n_reset),
		.push(push),
		.we(we),
		.addr_in(addr_in),
		.data_in(data_in),
		.pop(pop),
		.full(full),
		.empty(empty),
		.q_we(q_we),
		.q_addr(q_addr),
		.q_data(q_data)
	);

	command_sequencer #(
		.CAS(CAS),
		.TINIT(TINIT),
		.TREFC(TREFC),
		.TRC(TRC),
		.TRP(TRP),
		.TMRD(TMRD),
		.TRCD(TRCD)
	) u_seq (
		.clk(clk),
		.n_reset(n_reset),
		.empty(empty),
		.q_we(q_we),
		.q_addr(q_addr),
		.q_data(q_data),
		.pop(pop),
		.cmd(cmd),
		.dq_drive(dq_drive),
		.dq_out(dq_out),
		.dram_cke(DRAM_CKE),
		.dram_ras_n(DRAM_RAS_N),
		.dram_cas_n(DRAM_CAS_N),
		.dram_we_n(DRAM_WE_N),
		.dram_ba(DRAM_BA),
		.dram_addr(DRAM_ADDR),
		.dram_dqm(DRAM_DQM)
	);

	read_return #(
		.CAS(CAS)
	) u_ret (
		.clk(clk),
		.n_reset(n_reset),
		.cmd(cmd),
		.q_addr(q_addr),
		.dram_dq(DRAM_DQ),
		.rdy_out(rdy_out),
		.addr_out(addr_out),
		.data_out(data_out)
	);

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic n_reset
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;

	initial begin
		n_reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		n_reset = 1'b1;
	end

endmodule

//--- bench/sdram_device.sv
`timescale 1ns/10ps

module sdram_device #(
	parameter int CAS = 3,
	parameter int TRP = 3,
	parameter int TRCD = 3,
	parameter int TRC = 9,
	parameter int TREFC = 300
) (
	input logic clk,
	input logic n_reset,
	input logic cke,
	input logic cs_n,
	input logic ras_n,
	input logic cas_n,
	input logic we_n,
	input logic [1:0] ba,
	input logic [12:0] addr,
	input logic [1:0] dqm,
	inout wire [15:0] dq,
	output logic error,
	output logic init_done
);

	logic [15:0] mem [int];
	logic open_bank [4];
	logic [12:0] open_row [4];
	int pre_cyc [4];
	int act_cyc [4];
	logic [CAS-1:0] rv;
	logic [15:0] rdat [CAS];
	int cyc;
	int last_ref;
	int step;
	logic [2:0] code;
	int key;

	assign code = {ras_n, cas_n, we_n};
	assign key = {8'd0, ba, open_row[ba], addr[8:0]};
	// Read data driven in the cycle before the controller captures it
	assign dq = rv[CAS-1] ? rdat[CAS-1] : 'z;
	assign init_done = (step == 4);

	task automatic report(input string msg);
		$display("SDRAM protocol error at cycle %0d: %s", cyc, msg);
		error <= 1'b1;
	endtask

	always @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			cyc <= 0;
			last_ref <= 0;
			step <= 0;
			rv <= '0;
			error <= 1'b0;
			for (int i = 0; i < 4; i++) begin
				open_bank[i] <= 1'b0;
				pre_cyc[i] <= -100;
				act_cyc[i] <= -100;
			end
		end else begin
			cyc <= cyc + 1;
			rv[0] <= 1'b0;
			for (int i = 1; i < CAS; i++) begin
				rv[i] <= rv[i-1];
				rdat[i] <= rdat[i-1];
			end
			if (step == 4 && cyc - last_ref > TREFC + TRC)
				report("refresh interval exceeded");
			if (cke && !cs_n) begin
				case (code)
					3'b011: begin
						if (step != 4)
							report("ACT before mode register set");
						if (open_bank[ba])
							report("ACT to a bank with an open row");
						if (cyc - pre_cyc[ba] < TRP)
							report("ACT too soon after precharge");
						open_bank[ba] <= 1'b1;
						open_row[ba] <= addr;
						act_cyc[ba] <= cyc;
					end
					3'b101, 3'b100: begin
						if (step != 4)
							report("access before mode register set");
						if (!open_bank[ba])
							report("access to a bank without an open row");
						if (cyc - act_cyc[ba] < TRCD)
							report("access too soon after ACT");
						if (dqm != 2'b00)
							report("access with data masked");
						if (code == 3'b100) begin
							mem[key] = dq;
						end else begin
							rv[0] <= 1'b1;
							rdat[0] <= mem.exists(key) ? mem[key] : 16'h0000;
						end
					end
					3'b010: begin
						if (addr[10]) begin
							if (step == 0)
								step <= 1;
							for (int i = 0; i < 4; i++) begin
								open_bank[i] <= 1'b0;
								pre_cyc[i] <= cyc;
							end
						end else begin
							if (step != 4)
								report("bank precharge during init");
							open_bank[ba] <= 1'b0;
							pre_cyc[ba] <= cyc;
						end
					end
					3'b001: begin
						if (step == 0 || step == 3)
							report("refresh out of init order");
						else if (step < 3)
							step <= step + 1;
						last_ref <= cyc;
					end
					3'b000: begin
						if (step != 3)
							report("mode register set out of init order");
						if (addr[6:4] != 3'(CAS) || addr[3:0] != 4'b0000)
							report("mode word has wrong CAS or burst setting");
						step <= 4;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

//--- bench/tb_sdram_ctrl.sv
`timescale 1ns/10ps

module tb_sdram_ctrl;

	localparam int CAS = 3;
	localparam int TINIT = 40;
	localparam int TREFC = 300;
	localparam int TRC = 9;
	localparam int TRP = 3;
	localparam int TMRD = 2;
	localparam int TRCD = 3;
	localparam int REQUESTS = 400;
	localparam int WATCHDOG_NS = (TINIT + REQUESTS * 20 + 1000) * 100;

	logic clk;
	logic n_reset;
	logic en;
	logic req;
	logic we;
	logic [23:0] addr_in;
	logic [15:0] data_in;
	logic rdy;
	logic rdy_out;
	logic [23:0] addr_out;
	logic [15:0] data_out;
	logic [12:0] dram_addr;
	logic [1:0] dram_ba;
	logic [1:0] dram_dqm;
	logic dram_cke;
	logic dram_clk;
	logic dram_cs_n;
	logic dram_ras_n;
	logic dram_cas_n;
	logic dram_we_n;
	wire [15:0] dram_dq;
	logic dev_error;
	logic dev_init_done;

	integer seed;
	int cyc;
	int read_count;
	int resp_count;
	logic rdy_low_seen;
	logic [15:0] model [logic [23:0]];
	logic [23:0] exp_addr [$];
	logic [15:0] exp_data [$];

	clock_gen u_clk (
		.clk(clk),
		.n_reset(n_reset)
	);

	sdram_device #(
		.CAS(CAS),
		.TRP(TRP),
		.TRCD(TRCD),
		.TRC(TRC),
		.TREFC(TREFC)
	) u_dev (
		.clk(clk),
		.n_reset(n_reset),
		.cke(dram_cke),
		.cs_n(dram_cs_n),
		.ras_n(dram_ras_n),
		.cas_n(dram_cas_n),
		.we_n(dram_we_n),
		.ba(dram_ba),
		.addr(dram_addr),
		.dqm(dram_dqm),
		.dq(dram_dq),
		.error(dev_error),
		.init_done(dev_init_done)
	);

	sdram_ctrl #(
		.CAS(CAS),
		.TINIT(TINIT),
		.TREFC(TREFC),
		.TRC(TRC),
		.TRP(TRP),
		.TMRD(TMRD),
		.TRCD(TRCD),
		.QUEUE_DEPTH_LOG(3)
	) uut (
		.clk(clk),
		.n_reset(n_reset),
		.en(en),
		.req(req),
		.we(we),
		.addr_in(addr_in),
		.data_in(data_in),
		.rdy(rdy),
		.rdy_out(rdy_out),
		.addr_out(addr_out),
		.data_out(data_out),
		.DRAM_ADDR(dram_addr),
		.DRAM_BA(dram_ba),
		.DRAM_DQM(dram_dqm),
		.DRAM_CKE(dram_cke),
		.DRAM_CLK(dram_clk),
		.DRAM_CS_N(dram_cs_n),
		.DRAM_RAS_N(dram_ras_n),
		.DRAM_CAS_N(dram_cas_n),
		.DRAM_WE_N(dram_we_n),
		.DRAM_DQ(dram_dq)
	);

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	// Waits for rdy, then drives one request and updates the model
	task automatic send_request(input logic is_write);
		logic [23:0] a;
		logic [15:0] d;
		@(negedge clk);
		while (!rdy) begin
			req = 1'b0;
			rdy_low_seen = 1'b1;
			@(negedge clk);
		end
		a = {2'($random(seed) & 1), 13'($random(seed) & 3), 9'($random(seed) & 7)};
		d = 16'($random(seed));
		req = 1'b1;
		we = is_write;
		addr_in = a;
		data_in = d;
		if (is_write) begin
			model[a] = d;
		end else begin
			exp_addr.push_back(a);
			exp_data.push_back(model.exists(a) ? model[a] : 16'h0000);
		end
	endtask

	task automatic pause(input int n);
		@(negedge clk);
		req = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	// Keeps read data off the bus before a write burst
	task automatic wait_reads_done();
		@(negedge clk);
		req = 1'b0;
		while (exp_addr.size() != 0)
			@(negedge clk);
	endtask

	initial begin
		#(WATCHDOG_NS);
		fail_now("Timeout: simulation did not finish in time");
	end

	// Device clock settles just after each clk edge
	always @(clk) begin
		#1;
		assert (dram_clk === ~clk)
		else fail_now("DRAM_CLK is not the inverse of clk");
	end

	always @(posedge clk) begin
		if (n_reset) begin
			if (cyc < TINIT) begin
				assert ({dram_ras_n, dram_cas_n, dram_we_n} == 3'b111)
				else fail_now("A command other than NOP was issued during the init wait");
				assert (!rdy_out)
				else fail_now("rdy_out pulsed during the init wait");
				assert (!uut.dq_drive)
				else fail_now("Data bus was driven during the init wait");
			end
			assert (!dev_error)
			else fail_now("The SDRAM model reported a protocol error");
			if (req && rdy && !we)
				read_count++;
			if (rdy_out) begin
				assert (exp_addr.size() != 0)
				else fail_now("A response arrived with no read outstanding");
				assert (addr_out == exp_addr[0])
				else fail_now($sformatf("Fail addr_out: got %h, expected %h",
					addr_out, exp_addr[0]));
				assert (data_out == exp_data[0])
				else fail_now($sformatf("Fail data_out: got %h, expected %h",
					data_out, exp_data[0]));
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				resp_count++;
			end
			cyc++;
		end
	end

	initial begin
		int sent;
		int len;
		logic kind;
		logic last_read;
		en = 1'b1;
		req = 1'b0;
		we = 1'b0;
		addr_in = '0;
		data_in = '0;
		seed = 32'hd6da;
		cyc = 0;
		read_count = 0;
		resp_count = 0;
		rdy_low_seen = 1'b0;
		sent = 0;
		last_read = 1'b0;
		@(posedge n_reset);
		while (sent < REQUESTS) begin
			kind = 1'($random(seed) & 1);
			len = ($random(seed) & 15) + 1;
			if (last_read && kind)
				wait_reads_done();
			for (int i = 0; i < len && sent < REQUESTS; i++) begin
				send_request(kind);
				sent++;
			end
			last_read = !kind;
			pause($random(seed) & 3);
		end
		wait_reads_done();
		repeat (10) @(negedge clk);
		assert (dev_init_done)
		else fail_now("The init sequence never completed");
		assert (rdy_low_seen)
		else fail_now("rdy was never seen low under back-pressure");
		assert (resp_count == read_count)
		else fail_now($sformatf("Fail resp_count: got %h, expected %h",
			resp_count, read_count));
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- verilog.f
logic/sdram_pkg.sv
logic/request_queue.sv
logic/command_sequencer.sv
logic/read_return.sv
logic/sdram_ctrl.sv
bench/clock_gen.sv
bench/sdram_device.sv
bench/tb_sdram_ctrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_sdram_ctrl \
	-f verilog.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
	exit 1
fi
exit 0
